// File: design/core_pkg.sv
package core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int WEN_W      = 4;

    localparam logic [XLEN-1:0] PC_STEP = XLEN'(4);

    // 3R opcodes, inst[31:15]
    localparam logic [16:0] OPC_ADD_W = 17'h00020;
    localparam logic [16:0] OPC_SUB_W = 17'h00022;
    localparam logic [16:0] OPC_SLT   = 17'h00024;
    localparam logic [16:0] OPC_SLTU  = 17'h00025;
    localparam logic [16:0] OPC_AND   = 17'h00029;
    localparam logic [16:0] OPC_OR    = 17'h0002a;
    localparam logic [16:0] OPC_XOR   = 17'h0002b;

    // 2RI12 opcode, inst[31:22]
    localparam logic [9:0] OPC_ADDI_W = 10'h00a;
    // 1RI20 opcode, inst[31:25]
    localparam logic [6:0] OPC_LU12I_W = 7'h0a;

    typedef enum logic [3:0] {
        ALU_NONE,
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_LUI
    } alu_op_e;

    typedef struct packed {
        logic                  valid;
        alu_op_e               op;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rj;
        logic [REG_ADDR_W-1:0] rk;
        logic [XLEN-1:0]       imm;
        logic                  use_imm;
        logic                  writes_rd;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       inst;
    } decoded_uop_t;

    typedef struct packed {
        logic                  valid;
        logic                  writes_rd;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       inst;
    } exec_result_t;

    typedef struct packed {
        logic                  en;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } rf_write_t;

endpackage

// File: design/inst_decoder.sv
module inst_decoder (
    input  logic                     aclk,
    input  logic                     aresetn,
    input  logic                     i_inst_valid,
    input  logic [core_pkg::XLEN-1:0] i_inst,
    output core_pkg::decoded_uop_t   o_uop
);

    logic [core_pkg::XLEN-1:0] pc_q;
    core_pkg::decoded_uop_t    uop_d;
    core_pkg::decoded_uop_t    uop_q;

    // fetch address of the next accepted word
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            pc_q <= '0;
        end else if (i_inst_valid) begin
            pc_q <= pc_q + core_pkg::PC_STEP;
        end
    end

    always_comb begin
        uop_d.valid   = i_inst_valid;
        uop_d.rd      = i_inst[4:0];
        uop_d.rj      = i_inst[9:5];
        uop_d.rk      = i_inst[14:10];
        uop_d.pc      = pc_q;
        uop_d.inst    = i_inst;
        uop_d.op      = core_pkg::ALU_NONE;
        uop_d.use_imm = 1'b0;
        uop_d.imm     = '0;

        case (i_inst[31:15])
            core_pkg::OPC_ADD_W: uop_d.op = core_pkg::ALU_ADD;
            core_pkg::OPC_SUB_W: uop_d.op = core_pkg::ALU_SUB;
            core_pkg::OPC_SLT:   uop_d.op = core_pkg::ALU_SLT;
            core_pkg::OPC_SLTU:  uop_d.op = core_pkg::ALU_SLTU;
            core_pkg::OPC_AND:   uop_d.op = core_pkg::ALU_AND;
            core_pkg::OPC_OR:    uop_d.op = core_pkg::ALU_OR;
            core_pkg::OPC_XOR:   uop_d.op = core_pkg::ALU_XOR;
            default: begin
                if (i_inst[31:22] == core_pkg::OPC_ADDI_W) begin
                    uop_d.op      = core_pkg::ALU_ADD;
                    uop_d.use_imm = 1'b1;
                    uop_d.imm     = {{(core_pkg::XLEN-12){i_inst[21]}}, i_inst[21:10]};
                end else if (i_inst[31:25] == core_pkg::OPC_LU12I_W) begin
                    uop_d.op      = core_pkg::ALU_LUI;
                    uop_d.use_imm = 1'b1;
                    uop_d.imm     = {i_inst[24:5], 12'b0};
                end
            end
        endcase

        // only supported encodings with a nonzero rd write
        uop_d.writes_rd = ((i_inst[31:15] inside {core_pkg::OPC_ADD_W, core_pkg::OPC_SUB_W,
                                                   core_pkg::OPC_SLT, core_pkg::OPC_SLTU,
                                                   core_pkg::OPC_AND, core_pkg::OPC_OR,
                                                   core_pkg::OPC_XOR}) ||
                           (i_inst[31:22] == core_pkg::OPC_ADDI_W) ||
                           (i_inst[31:25] == core_pkg::OPC_LU12I_W)) &&
                          (uop_d.rd != '0);
    end

    // decode stage register
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            uop_q.valid <= 1'b0;
        end else begin
            uop_q <= uop_d;
        end
    end

    assign o_uop = uop_q;

    a_none_never_writes: assert property (
        @(posedge aclk) disable iff (!aresetn)
        uop_q.valid && (uop_q.op == core_pkg::ALU_NONE) |-> !uop_q.writes_rd
    );

endmodule

// File: design/register_file.sv
module register_file (
    input  logic                           aclk,
    input  logic [core_pkg::REG_ADDR_W-1:0] i_raddr_j,
    input  logic [core_pkg::REG_ADDR_W-1:0] i_raddr_k,
    input  core_pkg::rf_write_t             i_write,
    output logic [core_pkg::XLEN-1:0]       o_rdata_j,
    output logic [core_pkg::XLEN-1:0]       o_rdata_k
);

    logic [core_pkg::XLEN-1:0] regs [core_pkg::NUM_REGS];

    always_ff @(posedge aclk) begin
        if (i_write.en) begin
            regs[i_write.addr] <= i_write.data;
        end
    end

    // r0 reads as zero whatever the array holds
    assign o_rdata_j = (i_raddr_j == '0) ? '0 : regs[i_raddr_j];
    assign o_rdata_k = (i_raddr_k == '0) ? '0 : regs[i_raddr_k];

    a_no_r0_write: assert property (
        @(posedge aclk)
        i_write.en |-> (i_write.addr != '0)
    );

endmodule

// File: design/exec_unit.sv
module exec_unit (
    input  logic                           aclk,
    input  logic                           aresetn,
    input  core_pkg::decoded_uop_t          i_uop,
    input  logic [core_pkg::XLEN-1:0]       i_rdata_j,
    input  logic [core_pkg::XLEN-1:0]       i_rdata_k,
    output logic [core_pkg::REG_ADDR_W-1:0] o_raddr_j,
    output logic [core_pkg::REG_ADDR_W-1:0] o_raddr_k,
    output core_pkg::exec_result_t          o_result
);

    core_pkg::exec_result_t    result_q;
    logic                      fwd_j;
    logic                      fwd_k;
    logic [core_pkg::XLEN-1:0] src_j;
    logic [core_pkg::XLEN-1:0] src_k;
    logic [core_pkg::XLEN-1:0] op_b;
    logic [core_pkg::XLEN-1:0] alu_out;
    logic                      have_prev;
    logic [core_pkg::XLEN-1:0] prev_pc;

    assign o_raddr_j = i_uop.rj;
    assign o_raddr_k = i_uop.rk;

    // bypass from the instruction one ahead, which commits this cycle
    assign fwd_j = result_q.valid && result_q.writes_rd &&
                   (result_q.rd == i_uop.rj) && (i_uop.rj != '0);
    assign fwd_k = result_q.valid && result_q.writes_rd &&
                   (result_q.rd == i_uop.rk) && (i_uop.rk != '0);

    assign src_j = fwd_j ? result_q.data : i_rdata_j;
    assign src_k = fwd_k ? result_q.data : i_rdata_k;
    assign op_b  = i_uop.use_imm ? i_uop.imm : src_k;

    always_comb begin
        case (i_uop.op)
            core_pkg::ALU_ADD:  alu_out = src_j + op_b;
            core_pkg::ALU_SUB:  alu_out = src_j - op_b;
            core_pkg::ALU_SLT:  alu_out = {{(core_pkg::XLEN-1){1'b0}},
                                           $signed(src_j) < $signed(op_b)};
            core_pkg::ALU_SLTU: alu_out = {{(core_pkg::XLEN-1){1'b0}}, src_j < op_b};
            core_pkg::ALU_AND:  alu_out = src_j & op_b;
            core_pkg::ALU_OR:   alu_out = src_j | op_b;
            core_pkg::ALU_XOR:  alu_out = src_j ^ op_b;
            core_pkg::ALU_LUI:  alu_out = op_b;
            default:            alu_out = '0;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            result_q.valid <= 1'b0;
        end else begin
            result_q.valid     <= i_uop.valid;
            result_q.writes_rd <= i_uop.writes_rd;
            result_q.rd        <= i_uop.rd;
            result_q.data      <= alu_out;
            result_q.pc        <= i_uop.pc;
            result_q.inst      <= i_uop.inst;
        end
    end

    assign o_result = result_q;

    // pc of the last result seen, for the ordering check
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            have_prev <= 1'b0;
        end else if (result_q.valid) begin
            have_prev <= 1'b1;
            prev_pc   <= result_q.pc;
        end
    end

    a_pc_in_order: assert property (
        @(posedge aclk) disable iff (!aresetn)
        result_q.valid && have_prev |-> (result_q.pc == prev_pc + core_pkg::PC_STEP)
    );

endmodule

// File: design/commit_stage.sv
module commit_stage (
    input  logic                           aclk,
    input  logic                           aresetn,
    input  core_pkg::exec_result_t          i_result,
    output core_pkg::rf_write_t             o_rf_write,
    output logic                           o_debug_wb_valid,
    output logic [core_pkg::XLEN-1:0]       o_debug_wb_pc,
    output logic [core_pkg::WEN_W-1:0]      o_debug_wb_rf_wen,
    output logic [core_pkg::REG_ADDR_W-1:0] o_debug_wb_rf_wnum,
    output logic [core_pkg::XLEN-1:0]       o_debug_wb_rf_wdata,
    output logic [core_pkg::XLEN-1:0]       o_debug_wb_inst,
    output logic [core_pkg::XLEN-1:0]       o_inst_count
);

    // write lands at the same edge as the trace update
    always_comb begin
        o_rf_write.en   = i_result.valid && i_result.writes_rd;
        o_rf_write.addr = i_result.rd;
        o_rf_write.data = i_result.data;
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            o_debug_wb_valid  <= 1'b0;
            o_debug_wb_rf_wen <= '0;
        end else begin
            o_debug_wb_valid    <= i_result.valid;
            o_debug_wb_rf_wen   <= {core_pkg::WEN_W{o_rf_write.en}};
            o_debug_wb_pc       <= i_result.pc;
            o_debug_wb_rf_wnum  <= i_result.rd;
            o_debug_wb_rf_wdata <= i_result.data;
            o_debug_wb_inst     <= i_result.inst;
        end
    end

    // retired count, no-ops included
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            o_inst_count <= '0;
        end else if (i_result.valid) begin
            o_inst_count <= o_inst_count + 1'b1;
        end
    end

    a_trace_no_r0: assert property (
        @(posedge aclk) disable iff (!aresetn)
        (o_debug_wb_rf_wen != '0) |-> (o_debug_wb_rf_wnum != '0)
    );

endmodule

// File: design/core_top.sv
module core_top (
    input  logic                           aclk,
    input  logic                           aresetn,
    input  logic                           i_inst_valid,
    input  logic [core_pkg::XLEN-1:0]       i_inst,
    output logic                           o_debug_wb_valid,
    output logic [core_pkg::XLEN-1:0]       o_debug_wb_pc,
    output logic [core_pkg::WEN_W-1:0]      o_debug_wb_rf_wen,
    output logic [core_pkg::REG_ADDR_W-1:0] o_debug_wb_rf_wnum,
    output logic [core_pkg::XLEN-1:0]       o_debug_wb_rf_wdata,
    output logic [core_pkg::XLEN-1:0]       o_debug_wb_inst,
    output logic [core_pkg::XLEN-1:0]       o_inst_count
);

    core_pkg::decoded_uop_t          uop;
    core_pkg::exec_result_t          result;
    core_pkg::rf_write_t             rf_write;
    logic [core_pkg::REG_ADDR_W-1:0] raddr_j;
    logic [core_pkg::REG_ADDR_W-1:0] raddr_k;
    logic [core_pkg::XLEN-1:0]       rdata_j;
    logic [core_pkg::XLEN-1:0]       rdata_k;

    inst_decoder u_decoder (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .i_inst_valid (i_inst_valid),
        .i_inst       (i_inst),
        .o_uop        (uop)
    );

    register_file u_regfile (
        .aclk      (aclk),
        .i_raddr_j (raddr_j),
        .i_raddr_k (raddr_k),
        .i_write   (rf_write),
        .o_rdata_j (rdata_j),
        .o_rdata_k (rdata_k)
    );

    exec_unit u_exec (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .i_uop     (uop),
        .i_rdata_j (rdata_j),
        .i_rdata_k (rdata_k),
        .o_raddr_j (raddr_j),
        .o_raddr_k (raddr_k),
        .o_result  (result)
    );

    commit_stage u_commit (
        .aclk                (aclk),
        .aresetn             (aresetn),
        .i_result            (result),
        .o_rf_write          (rf_write),
        .o_debug_wb_valid    (o_debug_wb_valid),
        .o_debug_wb_pc       (o_debug_wb_pc),
        .o_debug_wb_rf_wen   (o_debug_wb_rf_wen),
        .o_debug_wb_rf_wnum  (o_debug_wb_rf_wnum),
        .o_debug_wb_rf_wdata (o_debug_wb_rf_wdata),
        .o_debug_wb_inst     (o_debug_wb_inst),
        .o_inst_count        (o_inst_count)
    );

endmodule

// File: test/tb_core.sv
module tb_core;

    typedef struct packed {
        logic [core_pkg::XLEN-1:0]       pc;
        logic [core_pkg::XLEN-1:0]       inst;
        logic [core_pkg::WEN_W-1:0]      wen;
        logic [core_pkg::REG_ADDR_W-1:0] wnum;
        logic [core_pkg::XLEN-1:0]       wdata;
        logic [31:0]                     due;
    } trace_t;

    typedef struct packed {
        logic [core_pkg::XLEN-1:0]       word;
        logic [7:0]                      gap;
        logic [core_pkg::WEN_W-1:0]      wen;
        logic [core_pkg::REG_ADDR_W-1:0] wnum;
        logic [core_pkg::XLEN-1:0]       wdata;
    } dir_entry_t;

    logic                            aclk;
    logic                            aresetn;
    logic                            i_inst_valid;
    logic [core_pkg::XLEN-1:0]       i_inst;
    logic                            o_debug_wb_valid;
    logic [core_pkg::XLEN-1:0]       o_debug_wb_pc;
    logic [core_pkg::WEN_W-1:0]      o_debug_wb_rf_wen;
    logic [core_pkg::REG_ADDR_W-1:0] o_debug_wb_rf_wnum;
    logic [core_pkg::XLEN-1:0]       o_debug_wb_rf_wdata;
    logic [core_pkg::XLEN-1:0]       o_debug_wb_inst;
    logic [core_pkg::XLEN-1:0]       o_inst_count;

    trace_t                    expected_q[$];
    dir_entry_t                directed_q[$];
    logic [core_pkg::XLEN-1:0] model_regs [core_pkg::NUM_REGS];
    logic [core_pkg::XLEN-1:0] model_pc = '0;
    logic [31:0]               lcg_state = 32'h995c_3a49;
    int                        edge_count = 0;
    int                        retired_count = 0;
    int                        total_planned = 0;
    int                        num_random = 200;

    core_top i_dut (.*);

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    always @(posedge aclk) begin
        edge_count <= edge_count + 1;
    end

    task automatic stop_run();
        $display("Finished with errors");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] rand_below(input logic [31:0] n);
        return (lcg_next() >> 8) % n;
    endfunction

    task automatic load_directed();
        int          fd;
        int          n;
        int          gap;
        string       line;
        logic [31:0] word;
        logic [31:0] wen;
        logic [31:0] wnum;
        logic [31:0] wdata;
        fd = $fopen("test/tb_core_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the directed data file test/tb_core_input.txt");
            stop_run();
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %d %h %h %h", word, gap, wen, wnum, wdata);
                if (n == 5) begin
                    directed_q.push_back({word, 8'(gap), 4'(wen), 5'(wnum), wdata});
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic send_inst(input logic [31:0] word, input int gap, input logic [3:0] wen,
                             input logic [4:0] wnum, input logic [31:0] wdata);
        trace_t t;
        t.pc    = model_pc;
        t.inst  = word;
        t.wen   = wen;
        t.wnum  = wnum;
        t.wdata = wdata;
        // trace valid three cycles after the strobe cycle
        t.due   = 32'(edge_count + 3);
        expected_q.push_back(t);
        model_pc     = model_pc + 32'd4;
        i_inst_valid = 1'b1;
        i_inst       = word;
        @(posedge aclk);
        #2;
        i_inst_valid = 1'b0;
        i_inst       = '0;
        repeat (gap) begin
            @(posedge aclk);
            #2;
        end
    endtask

    task automatic run_directed();
        foreach (directed_q[i]) begin
            // file results define the register state for the random phase
            if (directed_q[i].wen != '0) begin
                model_regs[directed_q[i].wnum] = directed_q[i].wdata;
            end
            send_inst(directed_q[i].word, int'(directed_q[i].gap), directed_q[i].wen,
                      directed_q[i].wnum, directed_q[i].wdata);
        end
    endtask

    task automatic run_random();
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] word;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic        wr;
        int          n;
        for (n = 0; n < num_random; n++) begin
            rd = 5'(rand_below(8));
            rj = 5'(rand_below(8));
            rk = 5'(rand_below(8));
            r  = lcg_next();
            a  = model_regs[rj];
            b  = model_regs[rk];
            wr = 1'b1;
            case (rand_below(10))
                0: begin
                    word = {core_pkg::OPC_ADD_W, rk, rj, rd};
                    res  = a + b;
                end
                1: begin
                    word = {core_pkg::OPC_SUB_W, rk, rj, rd};
                    res  = a - b;
                end
                2: begin
                    word = {core_pkg::OPC_SLT, rk, rj, rd};
                    res  = {31'b0, $signed(a) < $signed(b)};
                end
                3: begin
                    word = {core_pkg::OPC_SLTU, rk, rj, rd};
                    res  = {31'b0, a < b};
                end
                4: begin
                    word = {core_pkg::OPC_AND, rk, rj, rd};
                    res  = a & b;
                end
                5: begin
                    word = {core_pkg::OPC_OR, rk, rj, rd};
                    res  = a | b;
                end
                6: begin
                    word = {core_pkg::OPC_XOR, rk, rj, rd};
                    res  = a ^ b;
                end
                7: begin
                    word = {core_pkg::OPC_ADDI_W, r[11:0], rj, rd};
                    res  = a + {{20{r[11]}}, r[11:0]};
                end
                8: begin
                    word = {core_pkg::OPC_LU12I_W, r[19:0], rd};
                    res  = {r[19:0], 12'h000};
                end
                default: begin
                    // top bits all ones match no supported opcode
                    word = {17'h1ffff, r[14:0]};
                    res  = '0;
                    wr   = 1'b0;
                end
            endcase
            if (rd == 5'd0) wr = 1'b0;
            if (wr) model_regs[rd] = res;
            send_inst(word, int'(rand_below(4)), wr ? 4'hf : 4'h0, rd, res);
        end
    endtask

    task automatic check_trace();
        trace_t e;
        if (o_debug_wb_valid === 1'b1) begin
            assert (expected_q.size() != 0) else begin
                $display("A trace entry appeared at %0t with no instruction outstanding", $time);
                stop_run();
            end
            e = expected_q.pop_front();
            retired_count++;
            check_value("trace cycle", 32'(edge_count), e.due);
            check_value("o_debug_wb_pc", o_debug_wb_pc, e.pc);
            check_value("o_debug_wb_inst", o_debug_wb_inst, e.inst);
            check_value("o_debug_wb_rf_wen", 32'(o_debug_wb_rf_wen), 32'(e.wen));
            if (e.wen != '0) begin
                check_value("o_debug_wb_rf_wnum", 32'(o_debug_wb_rf_wnum), 32'(e.wnum));
                check_value("o_debug_wb_rf_wdata", o_debug_wb_rf_wdata, e.wdata);
            end
        end else begin
            assert (o_debug_wb_valid === 1'b0) else begin
                $display("o_debug_wb_valid is unknown at %0t", $time);
                stop_run();
            end
            check_value("o_debug_wb_rf_wen", 32'(o_debug_wb_rf_wen), 32'h0);
        end
        check_value("o_inst_count", o_inst_count, 32'(retired_count));
    endtask

    // outputs sampled on the falling edge
    initial begin
        forever begin
            @(negedge aclk);
            if (aresetn === 1'b1) check_trace();
        end
    end

    initial begin
        int limit;
        wait (total_planned != 0);
        limit = 4 * total_planned + 100;
        repeat (limit) @(posedge aclk);
        $display("Timeout: the run did not finish within %0d clock cycles", limit);
        stop_run();
    end

    initial begin
        aresetn      = 1'b0;
        i_inst_valid = 1'b0;
        i_inst       = '0;
        foreach (model_regs[i]) model_regs[i] = '0;
        load_directed();
        if (directed_q.size() == 0) begin
            $display("The directed data file holds no instructions");
            stop_run();
        end
        total_planned = directed_q.size() + num_random;
        repeat (16) @(posedge aclk);
        #2;
        aresetn = 1'b1;
        // idle window before the first strobe
        repeat (10) begin
            @(posedge aclk);
            #2;
        end
        run_directed();
        run_random();
        while (expected_q.size() != 0) @(posedge aclk);
        repeat (3) @(negedge aclk);
        check_value("o_inst_count", o_inst_count, 32'(total_planned));
        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: test/tb_core_input.txt
# columns: instruction word (hex), idle cycles after it (dec),
# expected write enable (hex), register number (hex), write data (hex)
15000001 0 f 01 80000000
02bffc02 0 f 02 ffffffff
02800405 0 f 05 00000001
00121423 0 f 03 00000001
00129424 0 f 04 00000000
00121446 0 f 06 00000001
00129447 1 f 07 00000000
00100823 0 f 03 7fffffff
00111464 1 f 04 7ffffffe
00158886 2 f 06 80000001
001484c7 0 f 07 80000000
001514e3 0 f 03 80000001
02a00064 0 f 04 7ffff801
02bffc84 0 f 04 7ffff800
15ffffe5 0 f 05 fffff000
14ffffe6 1 f 06 7ffff000
001018a7 0 f 07 7fffe000
02801420 0 0 00 00000000
ffffffff 0 0 1f 00000000
00100001 0 f 01 00000000
00000000 2 0 00 00000000
00151c02 0 f 02 7fffe000
00110803 3 f 03 80002000
00100c60 0 0 00 00000000
00128c04 0 f 04 00000001

// File: all.f
design/core_pkg.sv
design/inst_decoder.sv
design/register_file.sv
design/exec_unit.sv
design/commit_stage.sv
design/core_top.sv
test/tb_core.sv

// File: Makefile
TOP       ?= tb_core
BUILD_DIR ?= build
LOG       ?= sim.log
VERILATOR ?= verilator
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard design/*.sv) $(wildcard test/*.sv)

.PHONY: all compile run check clean

all: check

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)

check: run
	@if grep -q "Finished with errors" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "Finished with no errors" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
